// ==== Makefile ====
# Verilator build for the two-layer cnn pipeline.
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := cnn_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/cnn_ref_model.svh ====
//******************************
// cnn reference model
// frame generators and the two-layer chain on frames.
//******************************
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

typedef enum int {FILL_CONST, FILL_RAMP, FILL_RAND} fill_mode_e;

typedef int ref_frame_t [cnn_pkg::IN_LINE_LEN][cnn_pkg::IN_LINE_LEN];

// valid convolution of an n x n frame, then shift and clamp.
function automatic ref_frame_t ref_conv(ref_frame_t f, int n, cnn_pkg::kernel_t k, int sh);
    ref_frame_t o;
    int s;
    o = '{default: 0};
    for (int r = 0; r < n - 2; r++) begin
        for (int c = 0; c < n - 2; c++) begin
            s = 0;
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    s += f[r + i][c + j] * int'(k[i][j]);
                end
            end
            s = s >>> sh;
            o[r][c] = (s < 0) ? 0 : ((s > int'(cnn_pkg::PIX_MAX)) ? int'(cnn_pkg::PIX_MAX) : s);
        end
    end
    return o;
endfunction

function automatic ref_frame_t ref_pool(ref_frame_t f, int n);
    ref_frame_t o;
    int m;
    o = '{default: 0};
    for (int r = 0; r < n / 2; r++) begin
        for (int c = 0; c < n / 2; c++) begin
            m = f[2 * r][2 * c];
            m = (f[2 * r][2 * c + 1] > m) ? f[2 * r][2 * c + 1] : m;
            m = (f[2 * r + 1][2 * c] > m) ? f[2 * r + 1][2 * c] : m;
            m = (f[2 * r + 1][2 * c + 1] > m) ? f[2 * r + 1][2 * c + 1] : m;
            o[r][c] = m;
        end
    end
    return o;
endfunction

// the 3x3 result sits in the top-left corner.
function automatic ref_frame_t ref_chain(ref_frame_t f);
    ref_frame_t a;
    ref_frame_t b;
    a = ref_conv(f, cnn_pkg::IN_LINE_LEN, cnn_pkg::KERNEL_L0, cnn_pkg::SHIFT_L0);
    b = ref_pool(a, cnn_pkg::L0_CONV_LEN);
    return ref_conv(b, cnn_pkg::L1_LINE_LEN, cnn_pkg::KERNEL_L1, cnn_pkg::SHIFT_L1);
endfunction

function automatic ref_frame_t gen_frame(fill_mode_e mode, int val, inout int seed);
    ref_frame_t f;
    for (int r = 0; r < cnn_pkg::IN_LINE_LEN; r++) begin
        for (int c = 0; c < cnn_pkg::IN_LINE_LEN; c++) begin
            case (mode)
                FILL_CONST: f[r][c] = val & 255;
                FILL_RAMP:  f[r][c] = (val + 9 * r + 5 * c) % 256;
                default:    f[r][c] = $random(seed) & 255;
            endcase
        end
    end
    return f;
endfunction

`endif

// ==== bench/cnn_tb.sv ====
//******************************
// cnn testbench
// drives frames through the two layers, checks the model.
//******************************
`timescale 1ns/1ps

`include "cnn_ref_model.svh"

module cnn_tb;
    import cnn_pkg::*;

    localparam int OUT_LEN       = L1_LINE_LEN - 2;
    localparam int OUT_BEATS     = OUT_LEN * OUT_LEN;
    localparam int NUM_ROWS      = 9;
    localparam int FRAME_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES  = 40;

    typedef struct packed {
        fill_mode_e mode;
        int         val;
        logic       gap;
    } stim_row_t;

    // fill mode, fill value, idle cycles between beats.
    stim_row_t stim_tab [NUM_ROWS] = '{
        '{FILL_CONST, 0,   1'b0},
        '{FILL_CONST, 100, 1'b0},
        '{FILL_CONST, 255, 1'b1},
        '{FILL_RAMP,  0,   1'b0},
        '{FILL_RAMP,  77,  1'b1},
        '{FILL_RAND,  0,   1'b0},
        '{FILL_RAND,  0,   1'b1},
        '{FILL_RAND,  0,   1'b0},
        '{FILL_RAMP,  200, 1'b0}
    };

    logic       clk;
    logic       rst_n_i;
    stream_t    stream_i;
    stream_t    stream_o;
    int         seed;
    int         errors;
    int         timeouts;
    stream_t    out_q [$];
    ref_frame_t frames [NUM_ROWS];
    ref_frame_t exp_frames [NUM_ROWS];

    cnn_top dut_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stream_i (stream_i),
        .stream_o (stream_o)
    );

    always #10 clk = ~clk;

    // output beats, taken mid-cycle.
    always @(negedge clk) begin
        if (rst_n_i && stream_o.valid) begin
            out_q.push_back(stream_o);
        end
    end

    task automatic check_pix(input pix_t exp, input pix_t act, input string name);
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_marks(input stream_t exp, input stream_t act, input string name);
        logic [3:0] exp_m;
        logic [3:0] act_m;
        exp_m = {exp.sop, exp.eop, exp.sof, exp.eof};
        act_m = {act.sop, act.eop, act.sof, act.eof};
        if (act_m !== exp_m) begin
            errors++;
            $display("FAIL %0t %s sop/eop/sof/eof expected %b got %b",
                     $time, name, exp_m, act_m);
        end
    endtask

    task automatic check_valid(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic drive_beat(input stream_t b);
        @(posedge clk);
        #1;
        stream_i = b;
    endtask

    task automatic drive_frame(input ref_frame_t f, input logic gap);
        stream_t b;
        int      idle;
        for (int r = 0; r < IN_LINE_LEN; r++) begin
            for (int c = 0; c < IN_LINE_LEN; c++) begin
                b       = '0;
                b.valid = 1'b1;
                b.sop   = (c == 0);
                b.eop   = (c == IN_LINE_LEN - 1);
                b.sof   = (r == 0) && (c == 0);
                b.eof   = (r == IN_LINE_LEN - 1) && (c == IN_LINE_LEN - 1);
                b.data  = pix_t'(f[r][c]);
                drive_beat(b);
                if (gap) begin
                    idle = $unsigned($random(seed)) % 4;
                    repeat (idle) drive_beat('0);
                end
            end
        end
    endtask

    task automatic drive_all();
        for (int i = 0; i < NUM_ROWS; i++) begin
            drive_frame(frames[i], stim_tab[i].gap);
        end
        drive_beat('0);
    endtask

    task automatic check_frames();
        int      waited;
        int      r;
        int      c;
        stream_t beat;
        stream_t exp_beat;
        for (int i = 0; i < NUM_ROWS; i++) begin
            waited = 0;
            while (out_q.size() < OUT_BEATS && waited < FRAME_TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (out_q.size() < OUT_BEATS) begin
                timeouts++;
                $display("timeout: frame %0d produced only %0d of %0d outputs",
                         i, out_q.size(), OUT_BEATS);
                break;
            end
            for (int k = 0; k < OUT_BEATS; k++) begin
                r              = k / OUT_LEN;
                c              = k % OUT_LEN;
                beat           = out_q.pop_front();
                exp_beat       = '0;
                exp_beat.valid = 1'b1;
                exp_beat.sop   = (c == 0);
                exp_beat.eop   = (c == OUT_LEN - 1);
                exp_beat.sof   = (k == 0);
                exp_beat.eof   = (k == OUT_BEATS - 1);
                exp_beat.data  = pix_t'(exp_frames[i][r][c]);
                check_pix(exp_beat.data, beat.data,
                          $sformatf("stream_o.data frame %0d beat %0d", i, k));
                check_marks(exp_beat, beat,
                            $sformatf("stream_o frame %0d beat %0d", i, k));
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n_i  = 1'b0;
        stream_i = '0;
        seed     = 25918;
        errors   = 0;
        timeouts = 0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            frames[i]     = gen_frame(stim_tab[i].mode, stim_tab[i].val, seed);
            exp_frames[i] = ref_chain(frames[i]);
        end

        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // quiet output before any input.
        repeat (6) begin
            @(negedge clk);
            check_valid(1'b0, stream_o.valid, "stream_o.valid");
            check_marks('0, stream_o, "stream_o");
        end

        fork
            drive_all();
            check_frames();
        join

        if (timeouts == 0) begin
            repeat (DRAIN_CYCLES) @(posedge clk);
            if (out_q.size() != 0) begin
                errors++;
                $display("%0d output beats arrived beyond the expected frames",
                         out_q.size());
            end
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/cnn_pkg.sv ====
//******************************
// cnn package
// pixel, stream and window types, geometry and kernels.
//******************************
package cnn_pkg;

    typedef logic [7:0] pix_t;
    typedef logic signed [4:0] coef_t;
    typedef coef_t [2:0][2:0] kernel_t;
    typedef logic signed [17:0] acc_t;

    typedef struct packed {
        logic valid;
        logic sop;
        logic eop;
        logic sof;
        logic eof;
        pix_t data;
    } stream_t;

    // row 0 is the oldest line, column 0 the oldest pixel.
    typedef struct packed {
        logic            valid;
        logic            sop;
        logic            eop;
        logic            sof;
        logic            eof;
        pix_t [2:0][2:0] pix;
    } window_t;

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_FILL,
        WIN_RUN
    } win_state_e;

    localparam int IN_LINE_LEN = 12;
    localparam int L0_CONV_LEN = IN_LINE_LEN - 2;
    localparam int L1_LINE_LEN = L0_CONV_LEN / 2;

    localparam pix_t PIX_MAX = 8'd255;

    // smoothing, gain of 16.
    localparam kernel_t KERNEL_L0 = '{'{5'sd1, 5'sd2, 5'sd1},
                                      '{5'sd2, 5'sd4, 5'sd2},
                                      '{5'sd1, 5'sd2, 5'sd1}};
    localparam int SHIFT_L0 = 4;

    // edge detect, sums to zero.
    localparam kernel_t KERNEL_L1 = '{'{-5'sd1, -5'sd1, -5'sd1},
                                      '{-5'sd1, 5'sd8, -5'sd1},
                                      '{-5'sd1, -5'sd1, -5'sd1}};
    localparam int SHIFT_L1 = 0;

endpackage

// ==== hdl/cnn_top.sv ====
//******************************
// cnn top
// two convolution layers on a pixel stream.
//******************************
`timescale 1ns/1ps

module cnn_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  cnn_pkg::stream_t stream_i,
    output cnn_pkg::stream_t stream_o
);
    import cnn_pkg::*;

    window_t win0;
    stream_t conv0;
    stream_t pool0;
    window_t win1;

    // layer 0.
    line_window #(
        .line_len (IN_LINE_LEN)
    ) u_win0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .pix_i    (stream_i),
        .win_o    (win0)
    );

    conv3x3_relu #(
        .kernel   (KERNEL_L0),
        .shift    (SHIFT_L0)
    ) u_conv0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .win_i    (win0),
        .pix_o    (conv0)
    );

    max_pool2x2 #(
        .line_len (L0_CONV_LEN)
    ) u_pool0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .pix_i    (conv0),
        .pix_o    (pool0)
    );

    // layer 1 has no pooling.
    line_window #(
        .line_len (L1_LINE_LEN)
    ) u_win1 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .pix_i    (pool0),
        .win_o    (win1)
    );

    conv3x3_relu #(
        .kernel   (KERNEL_L1),
        .shift    (SHIFT_L1)
    ) u_conv1 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .win_i    (win1),
        .pix_o    (stream_o)
    );

endmodule

// ==== hdl/conv3x3_relu.sv ====
//******************************
// 3x3 convolution
// multiply-accumulate, shift and clamp to pixel range.
//******************************
`timescale 1ns/1ps

module conv3x3_relu #(
    parameter cnn_pkg::kernel_t kernel = cnn_pkg::KERNEL_L0,
    parameter int               shift  = cnn_pkg::SHIFT_L0
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  cnn_pkg::window_t win_i,
    output cnn_pkg::stream_t pix_o
);
    import cnn_pkg::*;

    acc_t       prod_q [3][3];
    // valid, sop, eop, sof, eof.
    logic [4:0] mark_q;
    acc_t       sum;
    acc_t       scaled;
    pix_t       clamped;

    // stage 1 products.
    always_ff @(posedge clk) begin
        if (win_i.valid) begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    prod_q[r][c] <= acc_t'($signed({1'b0, win_i.pix[r][c]})) *
                                    acc_t'(kernel[r][c]);
                end
            end
        end
        if (!rst_n_i) begin
            mark_q <= '0;
        end else begin
            mark_q <= {win_i.valid, win_i.sop, win_i.eop, win_i.sof, win_i.eof};
        end
    end

    always_comb begin
        sum = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                sum = sum + prod_q[r][c];
            end
        end
        scaled = sum >>> shift;
        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > acc_t'(PIX_MAX)) begin
            clamped = PIX_MAX;
        end else begin
            clamped = scaled[7:0];
        end
    end

    // stage 2 sum and relu.
    always_ff @(posedge clk) begin
        pix_o.data <= clamped;
        if (!rst_n_i) begin
            pix_o.valid <= 1'b0;
            pix_o.sop   <= 1'b0;
            pix_o.eop   <= 1'b0;
            pix_o.sof   <= 1'b0;
            pix_o.eof   <= 1'b0;
        end else begin
            pix_o.valid <= mark_q[4];
            pix_o.sop   <= mark_q[3];
            pix_o.eop   <= mark_q[2];
            pix_o.sof   <= mark_q[1];
            pix_o.eof   <= mark_q[0];
        end
    end

endmodule

// ==== hdl/line_window.sv ====
//******************************
// line window
// builds 3x3 pixel windows from a raster stream.
//******************************
`timescale 1ns/1ps

module line_window #(
    parameter int line_len = 12
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  cnn_pkg::stream_t pix_i,
    output cnn_pkg::window_t win_o
);
    import cnn_pkg::*;

    // two lines back and one line back.
    pix_t line_buf0 [line_len];
    pix_t line_buf1 [line_len];

    logic [$clog2(line_len)-1:0] col_q;
    logic [$clog2(line_len)-1:0] cur_col;
    logic [1:0]                  line_q;
    win_state_e                  state_q;
    logic                        first_q;
    logic                        run_start;
    logic                        in_run;
    logic                        win_vld;

    assign cur_col = pix_i.sop ? '0 : col_q;

    // third line of the frame begins.
    assign run_start = pix_i.valid && pix_i.sop && !pix_i.sof &&
                       (state_q == WIN_FILL) && (line_q == 2'd1);
    assign in_run    = ((state_q == WIN_RUN) && !pix_i.sof) || run_start;
    assign win_vld   = pix_i.valid && in_run && (cur_col >= 2);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= WIN_IDLE;
            col_q   <= '0;
            line_q  <= '0;
            first_q <= 1'b0;
        end else if (pix_i.valid) begin
            col_q <= cur_col + 1'b1;
            if (pix_i.sof) begin
                state_q <= WIN_FILL;
                line_q  <= '0;
                first_q <= 1'b1;
            end else begin
                if (pix_i.sop && line_q != 2'd2) begin
                    line_q <= line_q + 1'b1;
                end
                if (run_start) begin
                    state_q <= WIN_RUN;
                end else if (state_q == WIN_RUN && pix_i.eof) begin
                    state_q <= WIN_IDLE;
                end
                if (win_vld) begin
                    first_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_i.valid) begin
            line_buf0[cur_col] <= line_buf1[cur_col];
            line_buf1[cur_col] <= pix_i.data;
            for (int r = 0; r < 3; r++) begin
                win_o.pix[r][0] <= win_o.pix[r][1];
                win_o.pix[r][1] <= win_o.pix[r][2];
            end
            win_o.pix[0][2] <= line_buf0[cur_col];
            win_o.pix[1][2] <= line_buf1[cur_col];
            win_o.pix[2][2] <= pix_i.data;
        end
        if (!rst_n_i) begin
            win_o.valid <= 1'b0;
            win_o.sop   <= 1'b0;
            win_o.eop   <= 1'b0;
            win_o.sof   <= 1'b0;
            win_o.eof   <= 1'b0;
        end else begin
            win_o.valid <= win_vld;
            win_o.sop   <= win_vld && (cur_col == 2);
            win_o.eop   <= win_vld && pix_i.eop;
            win_o.sof   <= win_vld && first_q;
            win_o.eof   <= win_vld && pix_i.eof;
        end
    end

    a_eop_col: assert property (@(posedge clk) disable iff (!rst_n_i)
        pix_i.valid && pix_i.eop |-> cur_col == line_len - 1)
        else $error("line_window: eop away from the last column");

    a_mark_vld: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pix_i.sop || pix_i.eop || pix_i.sof || pix_i.eof) |-> pix_i.valid)
        else $error("line_window: marker without valid");

endmodule

// ==== hdl/max_pool2x2.sv ====
//******************************
// 2x2 max pooling
// maximum over non-overlapping 2x2 blocks.
//******************************
`timescale 1ns/1ps

module max_pool2x2 #(
    parameter int line_len = 10
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  cnn_pkg::stream_t pix_i,
    output cnn_pkg::stream_t pix_o
);
    import cnn_pkg::*;

    // pair maxima of the even line.
    pix_t half_buf [line_len/2];

    pix_t                        hold_q;
    logic [$clog2(line_len)-1:0] col_q;
    logic [$clog2(line_len)-1:0] cur_col;
    logic [$clog2(line_len)-2:0] pair_idx;
    logic                        odd_line_q;
    logic                        cur_odd_line;
    logic                        first_q;
    pix_t                        pair_max;
    pix_t                        blk_max;
    logic                        out_vld;

    function automatic pix_t max2(input pix_t a, input pix_t b);
        return (a > b) ? a : b;
    endfunction

    if ((line_len % 2) != 0) begin : g_len_chk
        $error("max_pool2x2: line_len must be even");
    end

    assign cur_col      = pix_i.sop ? '0 : col_q;
    assign pair_idx     = cur_col[$clog2(line_len)-1:1];
    assign cur_odd_line = pix_i.sof ? 1'b0 : (pix_i.sop ? ~odd_line_q : odd_line_q);
    assign pair_max     = max2(hold_q, pix_i.data);
    assign blk_max      = max2(half_buf[pair_idx], pair_max);
    assign out_vld      = pix_i.valid && cur_odd_line && cur_col[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            col_q      <= '0;
            odd_line_q <= 1'b0;
            first_q    <= 1'b0;
        end else if (pix_i.valid) begin
            col_q      <= cur_col + 1'b1;
            odd_line_q <= cur_odd_line;
            if (pix_i.sof) begin
                first_q <= 1'b1;
            end else if (out_vld) begin
                first_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_i.valid) begin
            if (!cur_col[0]) begin
                hold_q <= pix_i.data;
            end else if (!cur_odd_line) begin
                half_buf[pair_idx] <= pair_max;
            end
        end
        if (out_vld) begin
            pix_o.data <= blk_max;
        end
        if (!rst_n_i) begin
            pix_o.valid <= 1'b0;
            pix_o.sop   <= 1'b0;
            pix_o.eop   <= 1'b0;
            pix_o.sof   <= 1'b0;
            pix_o.eof   <= 1'b0;
        end else begin
            pix_o.valid <= out_vld;
            pix_o.sop   <= out_vld && (cur_col == 1);
            pix_o.eop   <= out_vld && pix_i.eop;
            pix_o.sof   <= out_vld && first_q;
            pix_o.eof   <= out_vld && pix_i.eof;
        end
    end

    a_eop_odd: assert property (@(posedge clk) disable iff (!rst_n_i)
        pix_i.valid && pix_i.eop |-> cur_col[0])
        else $error("max_pool2x2: eop on an even column");

endmodule

// ==== list.f ====
+incdir+include
hdl/cnn_pkg.sv
hdl/line_window.sv
hdl/conv3x3_relu.sv
hdl/max_pool2x2.sv
hdl/cnn_top.sv
bench/cnn_tb.sv
